// File: Makefile
VERILATOR  = verilator
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
TOP        = tb_gmii_test_responder
FLIST      = flist.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "test failed" $(LOG) || ! grep -q "test passed" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: flist.f
+incdir+verilog
verilog/responder_pkg.sv
verilog/sync_fifo.sv
verilog/frame_decoder.sv
verilog/packet_processor.sv
verilog/frame_encoder.sv
verilog/config_regs.sv
verilog/gmii_test_responder.sv
verification/tb_clock_gen.sv
verification/tb_gmii_test_responder.sv

// File: verification/tb_clock_gen.sv
/* Testbench clock and reset generator, 4 ns tx_clk period */
`timescale 1ns/1ps
module tb_clock_gen #(
	parameter int RESET_CYCLES = 5
) (
	output logic tx_clk,
	output logic reset
);
	initial begin
		tx_clk = 1'b0;
		forever #2 tx_clk = ~tx_clk;
	end

	// Released on a falling edge like every other DUT input
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge tx_clk);
		@(negedge tx_clk);
		reset = 1'b0;
	end

endmodule

// File: verification/tb_gmii_test_responder.sv
/* Testbench for the GMII test responder: frame table, GMII frame driver,
   reply monitor with scoreboard and register port accesses */
`timescale 1ns/1ps
`include "responder_settings.svh"
module tb_gmii_test_responder import responder_pkg::*; ();
	localparam int MAX_BYTES = `FRAME_MAX_BYTES;
	localparam int IFG = `IFG_CYCLES;
	localparam int NUM_ROWS = 18;
	localparam int WAIT_LIMIT = 4000;
	localparam logic [7:0] OP_BAD = 8'h7e;

	logic       tx_clk;
	logic       reset;
	logic [7:0] rxd;
	logic       rx_dv;
	logic       rx_er;
	logic [7:0] txd;
	logic       tx_en;
	logic       tx_er;
	logic       cfg_req;
	logic       cfg_we;
	logic [1:0] cfg_addr;
	logic [7:0] cfg_wdata;
	logic [7:0] cfg_rdata;
	logic       cfg_ack;
	logic [7:0] leds;
	logic       vcxo_en;

	// Frame table, one row per frame
	logic [7:0] row_op [NUM_ROWS];
	int         row_lo [NUM_ROWS];
	int         row_hi [NUM_ROWS];
	bit         row_err [NUM_ROWS];
	bit         row_rx_en [NUM_ROWS];
	bit         row_reply [NUM_ROWS];
	bit         row_b2b [NUM_ROWS];
	int         row_count = 0;

	// Scoreboard
	logic [7:0] exp_bytes [$];
	int         exp_lens [$];
	logic [7:0] reply_bytes [$];
	int         replies_expected = 0;
	int         replies_seen = 0;
	int         check_errors = 0;
	int         timeouts = 0;
	logic [7:0] key_value = 8'h00;
	bit         rx_enabled = 1'b1;

	tb_clock_gen #(.RESET_CYCLES(5)) clock_gen (.tx_clk(tx_clk), .reset(reset));

	gmii_test_responder dut (
		.tx_clk(tx_clk), .reset(reset),
		.rxd(rxd), .rx_dv(rx_dv), .rx_er(rx_er),
		.txd(txd), .tx_en(tx_en), .tx_er(tx_er),
		.cfg_req(cfg_req), .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
		.cfg_rdata(cfg_rdata), .cfg_ack(cfg_ack), .leds(leds), .vcxo_en(vcxo_en)
	);

	task automatic report_check(input string msg);
		check_errors++;
		$display("CHECK FAILED at %0t: %s", $time, msg);
	endtask

	task automatic print_counts();
		$display("Errors: %0d failed checks, %0d timeouts", check_errors, timeouts);
	endtask

	task automatic stop_on_timeout(input string what);
		timeouts++;
		$display("Timed out at %0t while waiting for %s", $time, what);
		print_counts();
		$display("test failed");
		$finish;
	endtask

	task automatic add_row(input logic [7:0] op, input int lo, input int hi, input bit err,
			input bit rx_en, input bit reply, input bit b2b);
		row_op[row_count] = op;
		row_lo[row_count] = lo;
		row_hi[row_count] = hi;
		row_err[row_count] = err;
		row_rx_en[row_count] = rx_en;
		row_reply[row_count] = reply;
		row_b2b[row_count] = b2b;
		row_count++;
	endtask

	// Opcode, length range, rx_er, receive enable, reply expected, back-to-back
	task automatic build_table();
		add_row(OP_ECHO, 1, MAX_BYTES, 0, 1, 1, 0);
		add_row(OP_INVERT, 1, MAX_BYTES, 0, 1, 1, 0);
		add_row(OP_XOR_KEY, 1, MAX_BYTES, 0, 1, 1, 0);
		add_row(OP_ECHO, MAX_BYTES, MAX_BYTES, 0, 1, 1, 0);
		add_row(OP_INVERT, 1, 1, 0, 1, 1, 0);
		add_row(OP_ECHO, 2, MAX_BYTES, 1, 1, 0, 0);
		add_row(OP_BAD, 1, MAX_BYTES, 0, 1, 0, 0);
		add_row(OP_ECHO, MAX_BYTES + 1, MAX_BYTES + 16, 0, 1, 0, 0);
		add_row(OP_XOR_KEY, 1, MAX_BYTES, 0, 1, 1, 0);
		// Receive disabled, then enabled again
		add_row(OP_INVERT, 1, MAX_BYTES, 0, 0, 0, 0);
		add_row(OP_ECHO, 1, MAX_BYTES, 0, 0, 0, 0);
		add_row(OP_XOR_KEY, 1, MAX_BYTES, 0, 1, 1, 0);
		// Short frames kept small so the FIFOs never refuse one
		add_row(OP_ECHO, 1, 16, 0, 1, 1, 0);
		add_row(OP_INVERT, 1, 16, 0, 1, 1, 1);
		add_row(OP_XOR_KEY, 1, 16, 0, 1, 1, 1);
		add_row(OP_ECHO, 1, 16, 0, 1, 1, 1);
		add_row(8'h55, 1, 16, 0, 1, 0, 1);
		add_row(OP_INVERT, 1, 16, 0, 1, 1, 1);
	endtask

	// Reply byte from the opcode rules, opcode byte returned as is
	function automatic logic [7:0] reply_byte(input logic [7:0] op, input logic [7:0] b,
			input int idx);
		if (idx == 0)
			return b;
		case (op)
			OP_INVERT: return ~b;
			OP_XOR_KEY: return b ^ key_value;
			default: return b;
		endcase
	endfunction

	task automatic wait_reset_release();
		int waited;
		waited = 0;
		// Reset is asserted by the first falling edge
		@(negedge tx_clk);
		while (reset) begin
			if (waited == WAIT_LIMIT)
				stop_on_timeout("reset release");
			@(negedge tx_clk);
			waited++;
		end
	endtask

	// Four-phase access, ack expected two edges after each req change
	task automatic reg_access(input bit we, input logic [1:0] addr, input logic [7:0] wdata,
			output logic [7:0] rdata);
		int waited;
		assert (cfg_ack == 1'b0) else report_check("cfg_ack high before a new request");
		cfg_we = we;
		cfg_addr = addr;
		cfg_wdata = wdata;
		@(negedge tx_clk);
		cfg_req = 1'b1;
		waited = 0;
		while (!cfg_ack) begin
			if (waited == WAIT_LIMIT)
				stop_on_timeout("cfg_ack to rise");
			@(negedge tx_clk);
			waited++;
		end
		assert (waited == 2) else report_check($sformatf("ack rose after %0d cycles", waited));
		rdata = cfg_rdata;
		cfg_req = 1'b0;
		waited = 0;
		while (cfg_ack) begin
			if (waited == WAIT_LIMIT)
				stop_on_timeout("cfg_ack to fall");
			@(negedge tx_clk);
			waited++;
		end
		assert (waited == 2) else report_check($sformatf("ack fell after %0d cycles", waited));
	endtask

	task automatic reg_write(input logic [1:0] addr, input logic [7:0] data);
		logic [7:0] unused_rdata;
		reg_access(1'b1, addr, data, unused_rdata);
	endtask

	task automatic reg_read_expect(input logic [1:0] addr, input logic [7:0] want);
		logic [7:0] got;
		reg_access(1'b0, addr, 8'h00, got);
		assert (got == want) else
			report_check($sformatf("register %0d read %h, expected %h", addr, got, want));
	endtask

	task automatic drive_byte(input logic [7:0] b, input logic er);
		rx_dv = 1'b1;
		rxd = b;
		rx_er = er;
		@(negedge tx_clk);
	endtask

	task automatic send_frame(input logic [7:0] op, input int len, input bit err,
			input bit reply);
		logic [7:0] payload [$];
		int pre_len;
		int err_idx;
		int i;
		pre_len = 3 + int'($urandom % 5);
		err_idx = err ? int'($urandom % len) : -1;
		payload.push_back(op);
		for (i = 1; i < len; i++)
			payload.push_back(8'($urandom));
		if (reply) begin
			for (i = 0; i < len; i++)
				exp_bytes.push_back(reply_byte(op, payload[i], i));
			exp_lens.push_back(len);
			replies_expected++;
		end
		for (i = 0; i < pre_len; i++)
			drive_byte(8'h55, 1'b0);
		drive_byte(8'hd5, 1'b0);
		for (i = 0; i < len; i++)
			drive_byte(payload[i], i == err_idx);
		rx_dv = 1'b0;
		rxd = 8'h00;
		rx_er = 1'b0;
		// Idle gap between input frames
		repeat (7) @(negedge tx_clk);
	endtask

	task automatic wait_replies();
		int waited;
		waited = 0;
		while (replies_seen != replies_expected) begin
			if (waited == WAIT_LIMIT)
				stop_on_timeout("expected reply frames");
			@(negedge tx_clk);
			waited++;
		end
	endtask

	task automatic check_reply();
		int len;
		int i;
		logic [7:0] want;
		replies_seen++;
		assert (exp_lens.size() > 0) else report_check("reply sent with no reply expected");
		if (exp_lens.size() == 0)
			return;
		len = exp_lens.pop_front();
		assert (reply_bytes.size() == len + 8) else
			report_check($sformatf("reply %0d is %0d bytes long, expected %0d",
				replies_seen, reply_bytes.size(), len + 8));
		// Seven 0x55 then the SFD
		for (i = 0; i < 8 && i < reply_bytes.size(); i++) begin
			want = (i == 7) ? 8'hd5 : 8'h55;
			assert (reply_bytes[i] == want) else
				report_check($sformatf("reply %0d preamble byte %0d is %h, expected %h",
					replies_seen, i, reply_bytes[i], want));
		end
		for (i = 0; i < len; i++) begin
			want = exp_bytes.pop_front();
			if (i + 8 < reply_bytes.size()) begin
				assert (reply_bytes[i + 8] == want) else
					report_check($sformatf("reply %0d byte %0d is %h, expected %h",
						replies_seen, i, reply_bytes[i + 8], want));
			end
		end
	endtask

	// Collects each tx_en burst and measures the idle run before it
	initial begin : reply_monitor
		bit in_frame;
		bit any_reply;
		int idle_run;
		in_frame = 1'b0;
		any_reply = 1'b0;
		idle_run = 0;
		forever begin
			@(negedge tx_clk);
			assert (tx_er == 1'b0) else report_check("tx_er is high");
			if (!reset) begin
				if (tx_en) begin
					if (!in_frame) begin
						in_frame = 1'b1;
						reply_bytes.delete();
						if (any_reply) begin
							assert (idle_run >= IFG) else
								report_check($sformatf("only %0d idle cycles between replies",
									idle_run));
						end
					end
					reply_bytes.push_back(txd);
				end else begin
					if (in_frame) begin
						in_frame = 1'b0;
						any_reply = 1'b1;
						idle_run = 0;
						check_reply();
					end
					idle_run++;
				end
			end
		end
	end

	initial begin : stimulus
		int r;
		int len;
		int drops_expected;
		logic [7:0] led_value;
		void'($urandom(32'he25cd8c5));
		rxd = 8'h00;
		rx_dv = 1'b0;
		rx_er = 1'b0;
		cfg_req = 1'b0;
		cfg_we = 1'b0;
		cfg_addr = 2'd0;
		cfg_wdata = 8'h00;
		drops_expected = 0;
		wait_reset_release();

		// State right after reset
		assert (tx_en == 1'b0) else report_check("tx_en high after reset");
		assert (cfg_ack == 1'b0) else report_check("cfg_ack high after reset");
		assert (leds == 8'h00) else report_check($sformatf("leds %h after reset", leds));
		assert (vcxo_en == 1'b1) else report_check("vcxo_en low after reset");
		reg_read_expect(REG_CONFIG, 8'h01);
		reg_read_expect(REG_DROPS, 8'h00);

		// LED byte, VCXO control and the read-only drop count
		led_value = 8'($urandom);
		reg_write(REG_LED, led_value);
		assert (leds == led_value) else report_check($sformatf("leds %h after write", leds));
		reg_read_expect(REG_LED, led_value);
		reg_write(REG_CONFIG, 8'h03);
		assert (vcxo_en == 1'b0) else report_check("vcxo_en high with VCXO disabled");
		reg_read_expect(REG_CONFIG, 8'h03);
		reg_write(REG_CONFIG, 8'h01);
		assert (vcxo_en == 1'b1) else report_check("vcxo_en low with VCXO enabled");
		reg_write(REG_DROPS, 8'h5a);
		reg_read_expect(REG_DROPS, 8'h00);

		// Nonzero key so XOR replies differ from echo
		key_value = 8'($urandom) | 8'h80;
		reg_write(REG_KEY, key_value);
		reg_read_expect(REG_KEY, key_value);

		build_table();
		for (r = 0; r < row_count; r++) begin
			// Paced rows start only once earlier replies are out
			if (!row_b2b[r])
				wait_replies();
			if (row_rx_en[r] != rx_enabled) begin
				rx_enabled = row_rx_en[r];
				reg_write(REG_CONFIG, {7'b0, rx_enabled});
			end
			len = row_lo[r] + int'($urandom % (row_hi[r] - row_lo[r] + 1));
			send_frame(row_op[r], len, row_err[r], row_reply[r]);
			if (!row_reply[r])
				drops_expected++;
		end
		wait_replies();

		// No stray reply may follow
		repeat (200) begin
			@(negedge tx_clk);
			assert (tx_en == 1'b0) else report_check("tx_en high after the last reply");
		end
		reg_read_expect(REG_DROPS, 8'(drops_expected));

		print_counts();
		if (check_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// File: verilog/config_regs.sv
/* Four-phase req/ack register port with configuration,
   LED, XOR key and saturating drop counter */
`timescale 1ns/1ps
`include "responder_settings.svh"
module config_regs import responder_pkg::*; (
	input  logic       tx_clk,
	input  logic       reset,
	input  logic       cfg_req,
	input  logic       cfg_we,
	input  logic [1:0] cfg_addr,
	input  logic [7:0] cfg_wdata,
	input  logic       drop_pulse,
	output logic [7:0] cfg_rdata,
	output logic       cfg_ack,
	output logic       rx_enable,
	output logic       vcxo_en,
	output logic [7:0] leds,
	output logic [7:0] xor_key
);
	logic       req_q;
	logic       access;
	logic [7:0] cfg_q;
	logic [7:0] led_q;
	logic [7:0] key_q;
	logic [7:0] drops_q;

	// One access per request, ack held until req drops
	assign access = req_q && !cfg_ack;

	always_ff @(posedge tx_clk) begin
		if (reset) begin
			req_q <= 1'b0;
			cfg_ack <= 1'b0;
			cfg_q <= `CFG_RESET_VALUE;
			led_q <= `LED_RESET_VALUE;
			key_q <= `KEY_RESET_VALUE;
			drops_q <= '0;
		end else begin
			req_q <= cfg_req;
			if (access)
				cfg_ack <= 1'b1;
			else if (!req_q)
				cfg_ack <= 1'b0;
			if (access && cfg_we) begin
				case (cfg_addr)
					REG_CONFIG: cfg_q <= cfg_wdata;
					REG_LED: led_q <= cfg_wdata;
					REG_KEY: key_q <= cfg_wdata;
					default: ;  // drop count is read only
				endcase
			end
			if (drop_pulse && drops_q != 8'hff)
				drops_q <= drops_q + 1'b1;
		end
	end

	always_ff @(posedge tx_clk) begin
		if (access) begin
			case (cfg_addr)
				REG_CONFIG: cfg_rdata <= cfg_q;
				REG_LED: cfg_rdata <= led_q;
				REG_KEY: cfg_rdata <= key_q;
				default: cfg_rdata <= drops_q;
			endcase
		end
	end

	assign rx_enable = cfg_q[0];
	// Bit 1 turns the VCXO off
	assign vcxo_en = ~cfg_q[1];
	assign leds = led_q;
	assign xor_key = key_q;

endmodule

// File: verilog/frame_decoder.sv
/* GMII receive front end: strips preamble and SFD,
   emits payload bytes as beats with first, last and error flags */
`timescale 1ns/1ps
module frame_decoder (
	input  logic       tx_clk,
	input  logic       reset,
	input  logic [7:0] rxd,
	input  logic       rx_dv,
	input  logic       rx_er,
	output logic       beat_valid,
	output logic [7:0] beat_data,
	output logic       beat_first,
	output logic       beat_last,
	output logic       beat_err
);
	typedef enum logic [1:0] {ST_IDLE, ST_PREAMBLE, ST_PAYLOAD} state_e;

	state_e     state;
	logic       hold_valid;
	logic       hold_first;
	logic [7:0] hold_data;
	logic       first_pend;
	logic       err_seen;

	always_ff @(posedge tx_clk) begin
		if (reset) begin
			state <= ST_IDLE;
			hold_valid <= 1'b0;
			hold_first <= 1'b0;
			first_pend <= 1'b0;
			err_seen <= 1'b0;
		end else begin
			// One byte of delay so the end of frame is known when it goes out
			hold_valid <= (state == ST_PAYLOAD) && rx_dv;
			hold_first <= (state == ST_PAYLOAD) && rx_dv && first_pend;
			case (state)
				ST_IDLE: begin
					if (rx_dv && rxd == 8'h55) begin
						state <= ST_PREAMBLE;
						err_seen <= rx_er;
					end
				end
				ST_PREAMBLE: begin
					if (!rx_dv) begin
						state <= ST_IDLE;
					end else begin
						err_seen <= err_seen | rx_er;
						if (rxd == 8'hd5) begin
							state <= ST_PAYLOAD;
							first_pend <= 1'b1;
						end else if (rxd != 8'h55) begin
							// Not a preamble after all
							state <= ST_IDLE;
						end
					end
				end
				ST_PAYLOAD: begin
					if (rx_dv) begin
						err_seen <= err_seen | rx_er;
						first_pend <= 1'b0;
					end else begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Payload byte, no reset needed
	always_ff @(posedge tx_clk) begin
		hold_data <= rxd;
	end

	assign beat_valid = hold_valid;
	assign beat_data = hold_data;
	assign beat_first = hold_first;
	// Held byte is the last one once rx_dv has dropped
	assign beat_last = hold_valid && !rx_dv;
	assign beat_err = hold_valid && err_seen;

endmodule

// File: verilog/frame_encoder.sv
/* Result stage: preamble, SFD and buffered reply bytes onto GMII,
   dropped frames discarded, inter-frame gap held */
`timescale 1ns/1ps
`include "responder_settings.svh"
module frame_encoder import responder_pkg::*; (
	input  logic          tx_clk,
	input  logic          reset,
	input  beat_t         data_rd_data,
	input  logic          data_empty,
	input  frame_status_t stat_rd_data,
	input  logic          stat_empty,
	output logic          data_rd_en,
	output logic          stat_rd_en,
	output logic [7:0]    txd,
	output logic          tx_en,
	output logic          tx_er
);
	localparam int GAP_W = $clog2(`IFG_CYCLES);

	typedef enum logic [2:0] {ST_IDLE, ST_PREAMBLE, ST_DATA, ST_DISCARD, ST_GAP} state_e;

	state_e           state;
	logic [2:0]       pre_cnt;
	logic [GAP_W-1:0] gap_cnt;
	logic [6:0]       byte_left;

	// Status record picks send or discard
	assign stat_rd_en = (state == ST_IDLE) && !stat_empty;
	assign data_rd_en = ((state == ST_DATA) || (state == ST_DISCARD)) && !data_empty;
	assign tx_er = 1'b0;

	always_ff @(posedge tx_clk) begin
		if (reset) begin
			state <= ST_IDLE;
			tx_en <= 1'b0;
			pre_cnt <= '0;
			gap_cnt <= '0;
			byte_left <= '0;
		end else begin
			tx_en <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (stat_rd_en) begin
						pre_cnt <= '0;
						// Reply length comes from the status record
						byte_left <= stat_rd_data.count;
						state <= stat_rd_data.drop ? ST_DISCARD : ST_PREAMBLE;
					end
				end
				ST_PREAMBLE: begin
					// Seven 0x55 then the SFD
					tx_en <= 1'b1;
					pre_cnt <= pre_cnt + 1'b1;
					if (pre_cnt == 3'd7)
						state <= ST_DATA;
				end
				ST_DATA: begin
					if (data_rd_en) begin
						tx_en <= 1'b1;
						byte_left <= byte_left - 1'b1;
						if (byte_left == 7'd1) begin
							state <= ST_GAP;
							gap_cnt <= GAP_W'(`IFG_CYCLES - 1);
						end
					end
				end
				ST_DISCARD: begin
					if (data_rd_en && data_rd_data.last)
						state <= ST_IDLE;
				end
				ST_GAP: begin
					if (gap_cnt == '0)
						state <= ST_IDLE;
					else
						gap_cnt <= gap_cnt - 1'b1;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge tx_clk) begin
		case (state)
			ST_PREAMBLE: txd <= (pre_cnt == 3'd7) ? 8'hd5 : 8'h55;
			ST_DATA: txd <= data_rd_data.data;
			default: txd <= 8'h00;
		endcase
	end

endmodule

// File: verilog/gmii_test_responder.sv
/* GMII packet test responder top level: decoder, processor,
   data and status FIFOs, encoder and register block */
`timescale 1ns/1ps
`include "responder_settings.svh"
module gmii_test_responder import responder_pkg::*; (
	input  logic       tx_clk,
	input  logic       reset,
	input  logic [7:0] rxd,
	input  logic       rx_dv,
	input  logic       rx_er,
	output logic [7:0] txd,
	output logic       tx_en,
	output logic       tx_er,
	input  logic       cfg_req,
	input  logic       cfg_we,
	input  logic [1:0] cfg_addr,
	input  logic [7:0] cfg_wdata,
	output logic [7:0] cfg_rdata,
	output logic       cfg_ack,
	output logic [7:0] leds,
	output logic       vcxo_en
);
	localparam int DATA_FREE_W = $clog2(`DATA_FIFO_DEPTH + 1);
	localparam int STAT_FREE_W = $clog2(`STAT_FIFO_DEPTH + 1);

	// Decoder to processor
	logic       beat_valid;
	logic [7:0] beat_data;
	logic       beat_first;
	logic       beat_last;
	logic       beat_err;

	// FIFO write and read sides
	logic                   data_wr_en;
	beat_t                  data_wr_data;
	logic [DATA_FREE_W-1:0] data_free;
	logic                   data_rd_en;
	beat_t                  data_rd_data;
	logic                   data_empty;
	logic                   stat_wr_en;
	frame_status_t          stat_wr_data;
	logic [STAT_FREE_W-1:0] stat_free;
	logic                   stat_rd_en;
	frame_status_t          stat_rd_data;
	logic                   stat_empty;

	// Register block
	logic       rx_enable;
	logic [7:0] xor_key;
	logic       drop_pulse;

	frame_decoder decoder (
		.tx_clk(tx_clk), .reset(reset),
		.rxd(rxd), .rx_dv(rx_dv), .rx_er(rx_er),
		.beat_valid(beat_valid), .beat_data(beat_data), .beat_first(beat_first),
		.beat_last(beat_last), .beat_err(beat_err)
	);

	packet_processor processor (
		.tx_clk(tx_clk), .reset(reset),
		.beat_valid(beat_valid), .beat_data(beat_data), .beat_first(beat_first),
		.beat_last(beat_last), .beat_err(beat_err),
		.rx_enable(rx_enable), .xor_key(xor_key),
		.data_free(data_free), .stat_free(stat_free),
		.data_wr_en(data_wr_en), .data_wr_data(data_wr_data),
		.stat_wr_en(stat_wr_en), .stat_wr_data(stat_wr_data),
		.drop_pulse(drop_pulse)
	);

	sync_fifo #(.payload_t(beat_t), .DEPTH(`DATA_FIFO_DEPTH)) data_fifo (
		.tx_clk(tx_clk), .reset(reset),
		.wr_en(data_wr_en), .wr_data(data_wr_data), .rd_en(data_rd_en),
		.rd_data(data_rd_data), .empty(data_empty), .free_count(data_free)
	);

	// One record per frame
	sync_fifo #(.payload_t(frame_status_t), .DEPTH(`STAT_FIFO_DEPTH)) stat_fifo (
		.tx_clk(tx_clk), .reset(reset),
		.wr_en(stat_wr_en), .wr_data(stat_wr_data), .rd_en(stat_rd_en),
		.rd_data(stat_rd_data), .empty(stat_empty), .free_count(stat_free)
	);

	frame_encoder encoder (
		.tx_clk(tx_clk), .reset(reset),
		.data_rd_data(data_rd_data), .data_empty(data_empty),
		.stat_rd_data(stat_rd_data), .stat_empty(stat_empty),
		.data_rd_en(data_rd_en), .stat_rd_en(stat_rd_en),
		.txd(txd), .tx_en(tx_en), .tx_er(tx_er)
	);

	config_regs regs (
		.tx_clk(tx_clk), .reset(reset),
		.cfg_req(cfg_req), .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
		.drop_pulse(drop_pulse),
		.cfg_rdata(cfg_rdata), .cfg_ack(cfg_ack),
		.rx_enable(rx_enable), .vcxo_en(vcxo_en), .leds(leds), .xor_key(xor_key)
	);

endmodule

// File: verilog/packet_processor.sv
/* Execute stage: opcode transform, drop decision,
   data and status FIFO writes */
`timescale 1ns/1ps
`include "responder_settings.svh"
module packet_processor import responder_pkg::*; (
	input  logic                                 tx_clk,
	input  logic                                 reset,
	input  logic                                 beat_valid,
	input  logic [7:0]                           beat_data,
	input  logic                                 beat_first,
	input  logic                                 beat_last,
	input  logic                                 beat_err,
	input  logic                                 rx_enable,
	input  logic [7:0]                           xor_key,
	input  logic [$clog2(`DATA_FIFO_DEPTH+1)-1:0] data_free,
	input  logic [$clog2(`STAT_FIFO_DEPTH+1)-1:0] stat_free,
	output logic                                 data_wr_en,
	output beat_t                                data_wr_data,
	output logic                                 stat_wr_en,
	output frame_status_t                        stat_wr_data,
	output logic                                 drop_pulse
);
	localparam int MAX_BYTES = `FRAME_MAX_BYTES;

	logic       early_q;
	logic       bad_q;
	logic [7:0] op_q;
	logic [6:0] cnt_q;
	logic       early_now;
	logic       cur_early;
	logic       cur_bad;
	logic       unknown_op;
	logic [7:0] cur_op;
	logic [7:0] xform;
	logic [6:0] next_cnt;

	always_comb begin
		// Reserve a whole maximum frame, one extra for the trailing last beat
		early_now = !rx_enable || (data_free < MAX_BYTES + 1) || (stat_free == '0);
		cur_early = beat_first ? early_now : early_q;
		cur_op = beat_first ? beat_data : op_q;
		if (beat_first)
			next_cnt = 7'd1;
		else if (cnt_q > 7'(MAX_BYTES))
			next_cnt = cnt_q;  // stop just past the limit
		else
			next_cnt = cnt_q + 7'd1;
		unknown_op = 1'b0;
		xform = beat_data;
		case (cur_op)
			OP_ECHO: xform = beat_data;
			OP_INVERT: xform = ~beat_data;
			OP_XOR_KEY: xform = beat_data ^ xor_key;
			default: unknown_op = 1'b1;
		endcase
		// Opcode byte goes back unchanged
		if (beat_first)
			xform = beat_data;
		cur_bad = (!beat_first && bad_q) || beat_err || unknown_op ||
			(next_cnt > 7'(MAX_BYTES));
	end

	always_ff @(posedge tx_clk) begin
		if (reset) begin
			data_wr_en <= 1'b0;
			stat_wr_en <= 1'b0;
			drop_pulse <= 1'b0;
			early_q <= 1'b1;
			bad_q <= 1'b0;
			cnt_q <= '0;
		end else begin
			// Oversize bytes beyond the limit are skipped, the last beat still lands
			data_wr_en <= beat_valid && !cur_early &&
				((next_cnt <= 7'(MAX_BYTES)) || beat_last);
			stat_wr_en <= beat_valid && beat_last && !cur_early;
			drop_pulse <= beat_valid && beat_last && (cur_early || cur_bad);
			if (beat_valid) begin
				early_q <= cur_early;
				bad_q <= cur_bad;
				cnt_q <= next_cnt;
			end
		end
	end

	always_ff @(posedge tx_clk) begin
		if (beat_valid && beat_first)
			op_q <= beat_data;
		data_wr_data <= '{last: beat_last, data: xform};
		stat_wr_data <= '{drop: cur_bad, count: next_cnt};
	end

endmodule

// File: verilog/responder_pkg.sv
/* Shared types: data beat, frame status record,
   opcode and register address encodings */
package responder_pkg;

	// One byte of buffered reply plus end-of-frame marker
	typedef struct packed {
		logic       last;
		logic [7:0] data;
	} beat_t;

	// One record per received frame
	typedef struct packed {
		logic       drop;
		logic [6:0] count;
	} frame_status_t;

	// First payload byte selects the transform
	typedef enum logic [7:0] {
		OP_ECHO    = 8'h00,
		OP_INVERT  = 8'h01,
		OP_XOR_KEY = 8'h02
	} opcode_e;

	typedef enum logic [1:0] {
		REG_CONFIG = 2'd0,
		REG_LED    = 2'd1,
		REG_KEY    = 2'd2,
		REG_DROPS  = 2'd3
	} reg_addr_e;

endpackage

// File: verilog/responder_settings.svh
/* Frame limits, FIFO depths, transmit gap and register reset values
   for the GMII test responder */
`ifndef RESPONDER_SETTINGS_SVH
`define RESPONDER_SETTINGS_SVH

// Largest accepted payload, opcode byte included
`define FRAME_MAX_BYTES 64
// Room for two maximum frames
`define DATA_FIFO_DEPTH 128
`define STAT_FIFO_DEPTH 4
// Minimum idle cycles between transmitted frames
`define IFG_CYCLES 12
// Receive enabled, VCXO left running
`define CFG_RESET_VALUE 8'h01
`define LED_RESET_VALUE 8'h00
`define KEY_RESET_VALUE 8'h00

`endif

// File: verilog/sync_fifo.sv
/* Single-clock FIFO with show-ahead read,
   type-parameterized payload and free-space count */
`timescale 1ns/1ps
module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 16
) (
	input  logic                         tx_clk,
	input  logic                         reset,
	input  logic                         wr_en,
	input  payload_t                     wr_data,
	input  logic                         rd_en,
	output payload_t                     rd_data,
	output logic                         empty,
	output logic [$clog2(DEPTH+1)-1:0]   free_count
);
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	payload_t      mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] used;
	logic          do_wr;
	logic          do_rd;

	// Writes into a full FIFO and reads from an empty one are ignored
	assign do_wr = wr_en && (used != CW'(DEPTH));
	assign do_rd = rd_en && !empty;
	assign empty = (used == '0);
	assign free_count = CW'(DEPTH) - used;
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge tx_clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: used <= used + 1'b1;
				2'b01: used <= used - 1'b1;
				default: used <= used;
			endcase
		end
	end

	always_ff @(posedge tx_clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

endmodule
